// ==== rom_hub.f ====
source/rom_pkg.sv
source/rom_req_if.sv
source/rom_download.sv
source/rom_slot.sv
source/rom_arbiter.sv
source/rom_hub.sv
test/sdram_model.sv
test/rom_hub_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ROM hub testbench with Verilator, run it and check the log

set -u
cd "$(dirname "$0")"

LOG=sim.log
BIN=sim_rom_hub

verilator --binary --timing -Wno-fatal \
    --top-module rom_hub_tb \
    --Mdir obj_dir \
    -o "$BIN" \
    -f rom_hub.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

// ==== test/rom_hub_tb.sv ====
// *********************************************************************
// Directed tests of the ROM hub against a behavioral SDRAM
// Image covers 64 bytes of each region and 16 PROM bytes
// *********************************************************************
`default_nettype none

module rom_hub_tb import rom_pkg::*; ();

    localparam int seed_value = 78;
    localparam int image_len  = 208;
    localparam int limit      = 200;   // Cycles allowed per wait

    logic clk = 1'b0;
    logic rst, downloading, ioctl_wr;
    logic [21:0] ioctl_addr;
    logic [7:0] ioctl_data;
    logic [21:0] prog_addr;
    logic [7:0] prog_data;
    logic [1:0] prog_mask;
    logic prog_we, prom_we;
    logic [7:0] prom_addr;
    logic [3:0] prom_data;
    logic sdram_req, sdram_ack, data_rdy;
    logic [21:0] sdram_addr;
    logic [31:0] data_read;
    logic main_cs, char_cs, scr_cs, main_ok, char_ok, scr_ok;
    logic [17:0] main_addr;
    logic [14:0] char_addr;
    logic [16:0] scr_addr;
    logic [7:0] main_data, char_data;
    logic [15:0] scr_data;

    logic [7:0] img [0:'h4000F];
    integer seed = seed_value;
    int req_count = 0;
    logic req_q = 1'b0;
    logic [21:0] grant_log [$];

    always #20 clk = ~clk;

    rom_hub u_rom_hub (.*);

    sdram_model #(.seed_init(seed_value)) u_sdram (.*);

    // Request rises and accepted read addresses seen at the port
    always @(posedge clk) begin
        req_q <= sdram_req;
        if (sdram_req && !req_q) req_count <= req_count + 1;
        if (sdram_req && sdram_ack) grant_log.push_back(sdram_addr);
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        abort_run();
    endtask

    function automatic int loader_addr(input int i);
        if (i < 64) return i;
        if (i < 128) return 'h10000 + i - 64;
        if (i < 192) return 'h20000 + i - 128;
        return int'(prom_start) + i - 192;
    endfunction

    function automatic logic slot_ok(input int which);
        return which == 0 ? main_ok : (which == 1 ? char_ok : scr_ok);
    endfunction

    function automatic logic [15:0] slot_data(input int which);
        return which == 0 ? {8'h00, main_data} : (which == 1 ? {8'h00, char_data} : scr_data);
    endfunction

    // Byte regions at twice the halfword offset; scroll reads little endian
    function automatic logic [15:0] expected_data(input int which, input int a);
        int b;
        if (which == 0) begin
            b = 2 * int'(main_offset) + a;
            return {8'h00, img[b]};
        end
        if (which == 1) begin
            b = 2 * int'(char_offset) + a;
            return {8'h00, img[b]};
        end
        b = 2 * int'(scr_offset) + 2 * a;
        return {img[b + 1], img[b]};
    endfunction

    task automatic fill_image();
        for (int i = 0; i < image_len; i++) img[loader_addr(i)] = 8'($random(seed));
    endtask

    task automatic expect_all_ok_low();
        check_value("main_ok", main_ok, 0);
        check_value("char_ok", char_ok, 0);
        check_value("scr_ok", scr_ok, 0);
    endtask

    task automatic load_image();
        int la;
        int t;
        logic [15:0] hw;
        logic [1:0] exp_mask;
        @(negedge clk);
        downloading = 1'b1;
        #1 expect_all_ok_low();
        for (int i = 0; i < image_len; i++) begin
            la = loader_addr(i);
            @(negedge clk);
            ioctl_addr = 22'(la);
            ioctl_data = img[la];
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            if (la >= int'(prom_start)) begin
                check_value("prom_we", prom_we, 1);
                check_value("prom_addr", prom_addr, la - int'(prom_start));
                check_value("prom_data", prom_data, img[la][3:0]);
                @(negedge clk);
                check_value("prom_we", prom_we, 0);
            end else begin
                exp_mask = ~(2'b01 << la[0]);   // Only the addressed lane enabled
                check_value("prog_we", prog_we, 1);
                check_value("prog_addr", prog_addr, la / 2);
                check_value("prog_data", prog_data, img[la]);
                check_value("prog_mask", prog_mask, exp_mask);
                t = 0;
                while (prog_we) begin
                    check_value("sdram_req", sdram_req, 0);
                    if (t == limit) report_timeout("prog_we to drop");
                    @(negedge clk);
                    t++;
                end
            end
            check_value("sdram_req", sdram_req, 0);
        end
        @(negedge clk);
        downloading = 1'b0;
        #1 expect_all_ok_low();
        // Lane contents in the SDRAM model
        for (int i = 0; i < 192; i++) begin
            la = loader_addr(i);
            hw = u_sdram.mem[la / 2];
            check_value("sdram byte", la[0] ? hw[15:8] : hw[7:0], img[la]);
        end
    endtask

    task automatic wait_ok(input int which);
        int t;
        t = 0;
        while (!slot_ok(which)) begin
            if (t == limit) report_timeout("a slot ok");
            @(negedge clk);
            #1 t++;
        end
    endtask

    task automatic read_slot(input int which, input int a, input bit miss);
        string name;
        @(negedge clk);
        case (which)
            0: begin
                main_cs   = 1'b1;
                main_addr = 18'(a);
                name      = "main_data";
            end
            1: begin
                char_cs   = 1'b1;
                char_addr = 15'(a);
                name      = "char_data";
            end
            default: begin
                scr_cs   = 1'b1;
                scr_addr = 17'(a);
                name     = "scr_data";
            end
        endcase
        #1;
        if (miss) begin
            check_value("ok before fetch", slot_ok(which), 0);
        end else begin
            check_value("ok on hit", slot_ok(which), 1);   // Same cycle as addr
        end
        wait_ok(which);
        check_value(name, slot_data(which), expected_data(which, a));
    endtask

    task automatic verify_slot_data();
        wait_ok(0);
        wait_ok(1);
        wait_ok(2);
        check_value("main_data", main_data, expected_data(0, main_addr));
        check_value("char_data", char_data, expected_data(1, char_addr));
        check_value("scr_data", scr_data, expected_data(2, scr_addr));
    endtask

    task automatic scattered_main_bytes();
        read_slot(0, 'h05, 1);
        read_slot(0, 'h11, 1);
        read_slot(0, 'h2e, 1);
        read_slot(0, 'h3b, 1);
        read_slot(0, 'h02, 1);
    endtask

    task automatic cached_word_hits();
        int base;
        base = req_count;
        read_slot(0, 'h30, 1);
        for (int a = 'h31; a <= 'h33; a++) read_slot(0, a, 0);
        check_value("request count", req_count - base, 1);
    endtask

    task automatic scroll_halfwords();
        read_slot(2, 'h00, 1);
        read_slot(2, 'h07, 1);
        read_slot(2, 'h1c, 1);
        read_slot(2, 'h1f, 1);
    endtask

    task automatic three_way_contention();
        @(negedge clk);
        grant_log.delete();
        main_cs   = 1'b1;
        char_cs   = 1'b1;
        scr_cs    = 1'b1;
        main_addr = 18'h08;
        char_addr = 15'h21;
        scr_addr  = 17'h0a;
        #1 expect_all_ok_low();
        verify_slot_data();
        check_value("grant count", grant_log.size(), 3);
        check_value("first grant", grant_log[0], main_offset + 22'd4);
        check_value("second grant", grant_log[1], scr_offset + 22'd10);
        check_value("third grant", grant_log[2], char_offset + 22'h10);
    endtask

    task automatic reload_image();
        fill_image();
        load_image();   // Consumers keep cs and addr
        verify_slot_data();
    endtask

    initial begin
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        main_cs     = 1'b0;
        char_cs     = 1'b0;
        scr_cs      = 1'b0;
        main_addr   = '0;
        char_addr   = '0;
        scr_addr    = '0;
        fill_image();
        repeat (2) @(negedge clk);
        check_value("prog_we", prog_we, 0);
        check_value("prom_we", prom_we, 0);
        check_value("sdram_req", sdram_req, 0);
        rst = 1'b0;
        load_image();
        scattered_main_bytes();
        cached_word_hits();
        scroll_halfwords();
        three_way_contention();
        reload_image();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/sdram_model.sv ====
// *********************************************************************
// Behavioral SDRAM with programming writes and delayed 32-bit reads
// Covers halfword addresses below 0x20000 only; no refresh
// *********************************************************************
`default_nettype none

module sdram_model #(
    parameter int seed_init = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    input  logic        prog_we,
    input  logic [21:0] prog_addr,
    input  logic [7:0]  prog_data,
    input  logic [1:0]  prog_mask,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [31:0] data_read
);

    logic [15:0] mem [0:131071];
    integer      seed;
    int          ack_delay;
    int          rd_count;              // Cycles left until data_rdy
    logic [16:0] rd_addr;

    initial begin
        seed      = seed_init;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        ack_delay = 0;
        rd_count  = 0;
        for (int i = 0; i < 131072; i++) begin
            mem[i] = i[15:0] ^ {16{i[16]}};
        end
    end

    always @(posedge clk) begin
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        if (rst) begin
            ack_delay <= 0;
            rd_count  <= 0;
        end else begin
            if (rd_count != 0) begin
                rd_count <= rd_count - 1;
                if (rd_count == 1) begin
                    data_rdy  <= 1'b1;
                    data_read <= {mem[rd_addr + 17'd1], mem[rd_addr]};
                end
            end
            // One access at a time, ack after a random wait
            if (!sdram_ack && rd_count == 0 && ((prog_we && downloading) || sdram_req)) begin
                if (ack_delay != 0) begin
                    ack_delay <= ack_delay - 1;
                end else begin
                    sdram_ack <= 1'b1;
                    ack_delay <= int'($unsigned($random(seed)) % 3);
                    if (prog_we && downloading) begin
                        if (!prog_mask[0]) mem[prog_addr[16:0]][7:0]  <= prog_data;
                        if (!prog_mask[1]) mem[prog_addr[16:0]][15:8] <= prog_data;
                    end else begin
                        rd_addr  <= sdram_addr[16:0];
                        rd_count <= 2 + int'($unsigned($random(seed)) % 4);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/rom_hub.sv ====
// *********************************************************************
// ROM hub top: loader download path, three cached read slots, arbiter
// SDRAM controller and refresh live outside; main and char are 8 bits
// *********************************************************************
`default_nettype none

module rom_hub import rom_pkg::*; #(
    parameter int main_aw = 18,
    parameter int char_aw = 15,
    parameter int scr_aw  = 17
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                downloading,
    // Loader
    input  logic                ioctl_wr,
    input  logic [21:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    // SDRAM programming
    output logic [21:0]         prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we,
    // Priority PROM
    output logic                prom_we,
    output logic [prom_aw-1:0]  prom_addr,
    output logic [3:0]          prom_data,
    // SDRAM read port
    output logic                sdram_req,
    output logic [sdram_aw-1:0] sdram_addr,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [31:0]         data_read,
    // Consumers
    input  logic                main_cs,
    input  logic [main_aw-1:0]  main_addr,
    output logic [7:0]          main_data,
    output logic                main_ok,
    input  logic                char_cs,
    input  logic [char_aw-1:0]  char_addr,
    output logic [7:0]          char_data,
    output logic                char_ok,
    input  logic                scr_cs,
    input  logic [scr_aw-1:0]   scr_addr,
    output logic [15:0]         scr_data,
    output logic                scr_ok
);

    rom_req_if main_bus ();
    rom_req_if char_bus ();
    rom_req_if scr_bus ();

    rom_download u_download (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   )
    );

    rom_slot #(.aw(main_aw), .dw(8), .offset(main_offset)) u_main (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .cs          ( main_cs     ),
        .addr        ( main_addr   ),
        .data        ( main_data   ),
        .ok          ( main_ok     ),
        .bus         ( main_bus    )
    );

    rom_slot #(.aw(char_aw), .dw(8), .offset(char_offset)) u_char (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .cs          ( char_cs     ),
        .addr        ( char_addr   ),
        .data        ( char_data   ),
        .ok          ( char_ok     ),
        .bus         ( char_bus    )
    );

    rom_slot #(.aw(scr_aw), .dw(16), .offset(scr_offset)) u_scr (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .cs          ( scr_cs      ),
        .addr        ( scr_addr    ),
        .data        ( scr_data    ),
        .ok          ( scr_ok      ),
        .bus         ( scr_bus     )
    );

    rom_arbiter u_arbiter (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .main_bus    ( main_bus    ),
        .scr_bus     ( scr_bus     ),
        .char_bus    ( char_bus    ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

`default_nettype wire

// ==== source/rom_arbiter.sv ====
// *********************************************************************
// Fixed priority main, scr, char on the single SDRAM read port
// Only one read outstanding; nothing is granted while downloading
// *********************************************************************
`default_nettype none

module rom_arbiter import rom_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                downloading,
    rom_req_if.arbiter          main_bus,
    rom_req_if.arbiter          scr_bus,
    rom_req_if.arbiter          char_bus,
    output logic                sdram_req,
    output logic [sdram_aw-1:0] sdram_addr,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  sdram_word_t         data_read
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_req  = 2'd1;
    localparam logic [1:0] st_wait = 2'd2;

    localparam logic [1:0] sel_main = 2'd0;
    localparam logic [1:0] sel_scr  = 2'd1;
    localparam logic [1:0] sel_char = 2'd2;

    logic [1:0]          state;
    logic [1:0]          sel;
    logic [sdram_aw-1:0] sel_addr;
    logic                busy;
    logic                back;

    assign busy = state != st_idle;
    assign back = (state == st_wait) && data_rdy;

    always_comb begin
        case (sel)
            sel_main: sel_addr = main_bus.addr;
            sel_scr:  sel_addr = scr_bus.addr;
            default:  sel_addr = char_bus.addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || downloading) begin
            state     <= st_idle;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (main_bus.req || scr_bus.req || char_bus.req) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (!sdram_req) begin
                        sdram_req <= 1'b1;        // Edge after the grant
                    end else if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= st_wait;
                    end
                end
                default: if (data_rdy) state <= st_idle;
            endcase
        end
    end

    // Winner latched on leaving idle
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            if (main_bus.req)     sel <= sel_main;
            else if (scr_bus.req) sel <= sel_scr;
            else                  sel <= sel_char;
        end
        if (state == st_req && !sdram_req) begin
            sdram_addr <= sel_addr;
        end
    end

    assign main_bus.grant = busy && (sel == sel_main);
    assign scr_bus.grant  = busy && (sel == sel_scr);
    assign char_bus.grant = busy && (sel == sel_char);

    // Returned word goes to every slot, rdy only to the owner
    assign main_bus.rdy  = back && (sel == sel_main);
    assign scr_bus.rdy   = back && (sel == sel_scr);
    assign char_bus.rdy  = back && (sel == sel_char);
    assign main_bus.word = data_read;
    assign scr_bus.word  = data_read;
    assign char_bus.word = data_read;

endmodule

`default_nettype wire

// ==== source/rom_slot.sv ====
// *********************************************************************
// Read-only consumer port with a one-word cache, dw must be 8 or 16
// ok needs cs, no download in progress and a cached word covering addr
// *********************************************************************
`default_nettype none

module rom_slot import rom_pkg::*; #(
    parameter int                  aw     = 18,
    parameter int                  dw     = 8,
    parameter logic [sdram_aw-1:0] offset = '0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          downloading,
    input  logic          cs,
    input  logic [aw-1:0] addr,
    output logic [dw-1:0] data,
    output logic          ok,
    rom_req_if.slot       bus
);

    // Low address bits that pick a byte or halfword inside the word
    localparam int lsb = (dw == 8) ? 2 : 1;
    localparam int tw  = aw - lsb;

    sdram_word_t   cache;
    logic [tw-1:0] tag;
    logic          valid;
    logic          hit;
    logic          miss;
    logic          fill;

    assign hit  = valid && (tag == addr[aw-1:lsb]);
    assign miss = cs && !downloading && !hit;
    assign ok   = cs && !downloading && hit;   // Combinational, same cycle as addr
    assign fill = bus.req && bus.rdy && bus.grant;

    always_ff @(posedge clk) begin
        if (rst || downloading) begin
            valid   <= 1'b0;               // New content invalidates the cache
            bus.req <= 1'b0;
        end else if (fill) begin
            valid   <= 1'b1;
            bus.req <= 1'b0;
        end else if (miss && !bus.req) begin
            valid   <= 1'b0;               // Tag is about to change
            bus.req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            cache <= bus.word;
        end
        if (miss && !bus.req) begin
            tag      <= addr[aw-1:lsb];
            // Two halfwords per tag step
            bus.addr <= offset + sdram_aw'({addr[aw-1:lsb], 1'b0});
        end
    end

    generate
        if (dw == 8) begin : g_byte
            assign data = cache.bytes[addr[1:0]];
        end else begin : g_half
            assign data = cache.halves[addr[0]];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== source/rom_download.sv ====
// *********************************************************************
// Loader bytes go to SDRAM below prom_start, to the PROM above it
// Loader writes must be spaced wider than one acknowledged SDRAM write
// *********************************************************************
`default_nettype none

module rom_download import rom_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               downloading,
    input  logic               ioctl_wr,
    input  logic [21:0]        ioctl_addr,
    input  logic [7:0]         ioctl_data,
    input  logic               sdram_ack,
    output logic [21:0]        prog_addr,
    output logic [7:0]         prog_data,
    output logic [1:0]         prog_mask,
    output logic               prog_we,
    output logic               prom_we,
    output logic [prom_aw-1:0] prom_addr,
    output logic [3:0]         prom_data
);

    logic loader_wr;
    logic is_prom;
    logic [21:0] prom_offset;

    assign loader_wr   = downloading && ioctl_wr;
    assign is_prom     = ioctl_addr >= prom_start;
    assign prom_offset = ioctl_addr - prom_start;

    // Control strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;                  // Single-cycle pulse
            if (loader_wr && is_prom) begin
                prom_we <= 1'b1;
            end else if (loader_wr) begin
                prog_we <= 1'b1;
            end else if (prog_we && sdram_ack) begin
                prog_we <= 1'b0;              // Held until the controller takes it
            end
        end
    end

    // Write payload, captured with the strobe
    always_ff @(posedge clk) begin
        if (loader_wr && is_prom) begin
            prom_addr <= prom_offset[prom_aw-1:0];
            prom_data <= ioctl_data[3:0];     // PROM is 4 bits wide
        end else if (loader_wr) begin
            prog_addr <= {1'b0, ioctl_addr[21:1]};   // Byte to halfword
            prog_data <= ioctl_data;
            // Active low lane enables
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

endmodule

`default_nettype wire

// ==== source/rom_req_if.sv ====
// *********************************************************************
// Fetch request link between one slot cache and the read arbiter
// addr is an even halfword address; rdy is a single-cycle pulse
// *********************************************************************
`default_nettype none

interface rom_req_if import rom_pkg::*; ();

    logic                req;
    logic [sdram_aw-1:0] addr;
    logic                grant;
    logic                rdy;
    sdram_word_t         word;

    modport slot (
        output req,
        output addr,
        input  grant,
        input  rdy,
        input  word
    );

    modport arbiter (
        input  req,
        input  addr,
        output grant,
        output rdy,
        output word
    );

endinterface

`default_nettype wire

// ==== source/rom_pkg.sv ====
// *********************************************************************
// Shared ROM map constants and the SDRAM read word
// SDRAM addresses count 16-bit halfwords; loader addresses count bytes
// *********************************************************************
`default_nettype none

package rom_pkg;

    localparam int sdram_aw = 22;   // Halfword address width
    localparam int prom_aw  = 8;

    // Region bases in SDRAM, in halfwords
    localparam logic [sdram_aw-1:0] main_offset = 22'h0_0000;
    localparam logic [sdram_aw-1:0] char_offset = 22'h0_8000;
    localparam logic [sdram_aw-1:0] scr_offset  = 22'h1_0000;

    // Loader bytes from here on go to the priority PROM
    localparam logic [21:0] prom_start = 22'h4_0000;

    // One 32-bit read covers two halfwords, lowest address in the low bits
    typedef union packed {
        logic [3:0][7:0]  bytes;    // 8-bit consumers
        logic [1:0][15:0] halves;   // 16-bit consumers
    } sdram_word_t;

endpackage

`default_nettype wire
